// File: src/lsu_pkg.sv
// Shared types for the load/store slice
// Structs are sized for 64-bit data; RV32 builds use only the low half
// Opcodes are instruction bits [6:2], the low two bits are not decoded

package lsu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int PKG_XLEN = 64;  // Struct data and address width
  localparam int EXC_W    = 16;  // Exception vector from decode

  //////////////////////////////
  // Opcodes, instr[6:2]
  //////////////////////////////
  localparam logic [4:0] OPC_LOAD  = 5'b00000;
  localparam logic [4:0] OPC_STORE = 5'b01000;

  //////////////////////////////
  // funct3 codes
  //////////////////////////////
  localparam logic [2:0] F3_B  = 3'b000;  // LB / SB
  localparam logic [2:0] F3_H  = 3'b001;  // LH / SH
  localparam logic [2:0] F3_W  = 3'b010;  // LW / SW
  localparam logic [2:0] F3_D  = 3'b011;  // LD / SD, RV64 only
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;
  localparam logic [2:0] F3_WU = 3'b110;  // RV64 only

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    BYTE  = 2'd0,
    HWORD = 2'd1,
    WORD  = 2'd2,
    DWORD = 2'd3
  } size_t;

  // Request from issue to the memory controller
  typedef struct packed {
    logic [PKG_XLEN-1:0] adr;          // Byte address
    logic [PKG_XLEN-1:0] d;            // Store data already in its byte lane
    logic                we;           // 1 for store
    size_t               size;
    logic                unsigned_ld;  // Zero-extend the load result
  } dmem_req_t;

  // Load result, already extended
  typedef struct packed {
    logic [PKG_XLEN-1:0] q;
  } dmem_rsp_t;

endpackage

// File: src/lsu_issue.sv
// Load/store issue stage
// Misaligned accesses are dropped with a one-cycle lsu_misaligned pulse
// LD, SD and LWU are illegal when XLEN is 32
// The caller holds its instruction while lsu_stall is high

`timescale 1ns/1ps

module lsu_issue import lsu_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ex_stall,
  input  logic             id_bubble,
  input  logic [31:0]      id_instr,
  input  logic [EXC_W-1:0] id_exception,
  input  logic [XLEN-1:0]  opA,
  input  logic [XLEN-1:0]  opB,
  input  logic             req_afull,      // Request FIFO near full
  output logic             lsu_stall,
  output logic             lsu_bubble,
  output logic [EXC_W-1:0] lsu_exception,
  output logic             lsu_misaligned,
  output logic             req_push,
  output dmem_req_t        req
);

  localparam int LSB = $clog2(XLEN / 8);  // Byte offset bits within a word

  logic [4:0]      opcode;
  logic [2:0]      funct3;
  logic            is_load;
  logic            is_store;
  logic            legal;      // Known load or store for this XLEN
  logic            aligned;
  logic            has_exc;
  logic            accept;
  logic            go;         // Legal, aligned, no exception
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] adr;
  logic [XLEN-1:0] st_raw;     // Store data before the lane shift
  logic [XLEN-1:0] st_lane;
  size_t           size;

  //////////////////////////////
  // Decode
  //////////////////////////////
  assign opcode   = id_instr[6:2];
  assign funct3   = id_instr[14:12];
  assign is_load  = (opcode == OPC_LOAD);
  assign is_store = (opcode == OPC_STORE);
  assign has_exc  = |id_exception;
  assign accept   = !id_bubble && !ex_stall && !lsu_stall;

  // S-type immediate, sign-extended
  assign imm_s = {{(XLEN-12){id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
  assign adr   = is_store ? opA + imm_s : opA + opB;

  always_comb begin
    legal = 1'b0;
    if (is_load) begin
      case (funct3)
        F3_B, F3_H, F3_W, F3_BU, F3_HU: legal = 1'b1;
        F3_D, F3_WU:                    legal = (XLEN == 64);  // RV64 only
        default:                        legal = 1'b0;
      endcase
    end else if (is_store) begin
      case (funct3)
        F3_B, F3_H, F3_W: legal = 1'b1;
        F3_D:             legal = (XLEN == 64);
        default:          legal = 1'b0;
      endcase
    end
  end

  // Size from funct3[1:0], the unsigned bit is funct3[2]
  always_comb begin
    case (funct3[1:0])
      2'b00:   size = BYTE;
      2'b01:   size = HWORD;
      2'b10:   size = WORD;
      default: size = DWORD;
    endcase
  end

  always_comb begin
    case (size)
      BYTE:    aligned = 1'b1;
      HWORD:   aligned = (adr[0] == 1'b0);
      WORD:    aligned = (adr[1:0] == 2'b00);
      default: aligned = (adr[2:0] == 3'b000);
    endcase
  end

  assign go = legal && aligned && !has_exc;

  //////////////////////////////
  // Store data lane
  //////////////////////////////
  always_comb begin
    case (size)
      BYTE:    st_raw = XLEN'(opB[7:0]);
      HWORD:   st_raw = XLEN'(opB[15:0]);
      WORD:    st_raw = XLEN'(opB[31:0]);
      default: st_raw = opB;
    endcase
  end

  assign st_lane = st_raw << {adr[LSB-1:0], 3'b000};  // Shift by byte offset

  //////////////////////////////
  // Control registers
  //////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lsu_stall      <= 1'b0;
      lsu_bubble     <= 1'b1;
      lsu_misaligned <= 1'b0;
      req_push       <= 1'b0;
      lsu_exception  <= '0;
    end else begin
      lsu_stall      <= req_afull;                             // One cycle behind the FIFO
      req_push       <= accept && go;
      lsu_misaligned <= accept && legal && !aligned && !has_exc;
      if (!ex_stall && !lsu_stall)
        lsu_bubble <= !(accept && go);                         // Anything not pushed is a bubble
      if (!lsu_stall)
        lsu_exception <= id_exception;
    end
  end

  // Request payload, loaded on every accepted instruction
  always_ff @(posedge clk) begin
    if (accept) begin
      req.adr         <= PKG_XLEN'(adr);
      req.d           <= PKG_XLEN'(st_lane);
      req.we          <= is_store;
      req.size        <= size;
      req.unsigned_ld <= funct3[2];
    end
  end

endmodule

// File: src/lsu_fifo.sv
// Synchronous FIFO carrying any packed payload type
// A push into a full FIFO is dropped, a pop from an empty one is ignored
// dout shows the head entry whenever empty is low
// afull also counts a push that lands at the next edge

`timescale 1ns/1ps

module lsu_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic [7:0]
) (
  input  logic clk,
  input  logic rstn,
  input  logic push,
  input  T     din,
  input  logic pop,
  output T     dout,
  output logic empty,
  output logic full,
  output logic afull   // At most one free entry once push lands
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
  localparam int CW = $clog2(DEPTH + 1);                // Count width

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CW'(DEPTH));
  assign afull = (int'(count) + int'(push)) >= DEPTH - 1;  // Pending push included
  assign dout  = mem[rd_ptr];  // Head entry

  // Payload storage
  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap for any depth
      if (do_pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// File: src/dmem_ctrl.sv
// Data memory controller on a small register-based memory
// Word index is the address modulo MEM_WORDS, upper address bits alias
// Requests are assumed aligned; issue drops misaligned ones
// Memory contents clear to zero at reset

`timescale 1ns/1ps

module dmem_ctrl import lsu_pkg::*; #(
  parameter int XLEN      = 64,
  parameter int MEM_WORDS = 32
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      req_empty,
  input  dmem_req_t req_head,
  input  logic      rsp_afull,
  output logic      req_pop,
  output logic      rsp_push,
  output dmem_rsp_t rsp
);

  localparam int NB    = XLEN / 8;             // Bytes per word
  localparam int LSB   = $clog2(NB);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [LSB-1:0]   off;
  logic [NB-1:0]    be_base;
  logic [NB-1:0]    be;
  logic [XLEN-1:0]  st_d;
  logic [XLEN-1:0]  rd_shift;
  logic [XLEN-1:0]  ld_ext;
  logic [XLEN-1:0]  ld_q;   // Load result register

  // Pop only when the response side has room for a load result
  assign req_pop = !req_empty && !rsp_afull;

  assign idx  = req_head.adr[LSB +: IDX_W];
  assign off  = req_head.adr[LSB-1:0];
  assign st_d = req_head.d[XLEN-1:0];

  //////////////////////////////
  // Byte enables
  //////////////////////////////
  always_comb begin
    case (req_head.size)
      BYTE:    be_base = NB'(1);
      HWORD:   be_base = NB'(3);
      WORD:    be_base = NB'(15);
      default: be_base = '1;
    endcase
  end

  assign be = be_base << off;

  // Memory array, byte writes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= '0;
    end else if (req_pop && req_head.we) begin
      for (int b = 0; b < NB; b++)
        if (be[b])
          mem[idx][8*b +: 8] <= st_d[8*b +: 8];
    end
  end

  //////////////////////////////
  // Load path
  //////////////////////////////
  assign rd_shift = mem[idx] >> {off, 3'b000};  // Selected bytes down to bit 0

  always_comb begin
    case (req_head.size)
      BYTE:    ld_ext = req_head.unsigned_ld ? XLEN'(rd_shift[7:0])
                                             : {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
      HWORD:   ld_ext = req_head.unsigned_ld ? XLEN'(rd_shift[15:0])
                                             : {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
      WORD:    ld_ext = req_head.unsigned_ld ? XLEN'(rd_shift[31:0])
                                             : XLEN'($signed(rd_shift[31:0]));
      default: ld_ext = rd_shift;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_pop)
      ld_q <= ld_ext;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      rsp_push <= 1'b0;
    else
      rsp_push <= req_pop && !req_head.we;  // Loads only
  end

  assign rsp.q = PKG_XLEN'(ld_q);

endmodule

// File: src/lsu_top.sv
// Load/store slice top level
// rsp_q is valid while rsp_valid is high; rsp_pop removes the head entry
// FIFO_DEPTH should be at least 2 so afull leaves room for the stall delay

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int XLEN       = 64,
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_WORDS  = 32
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ex_stall,
  input  logic             id_bubble,
  input  logic [31:0]      id_instr,
  input  logic [EXC_W-1:0] id_exception,
  input  logic [XLEN-1:0]  opA,
  input  logic [XLEN-1:0]  opB,
  output logic             lsu_stall,
  output logic             lsu_bubble,
  output logic [EXC_W-1:0] lsu_exception,
  output logic             lsu_misaligned,
  input  logic             rsp_pop,
  output logic             rsp_valid,
  output logic [XLEN-1:0]  rsp_q
);

  logic      req_push;
  logic      req_afull;
  logic      req_empty;
  logic      req_pop;
  logic      rsp_push;
  logic      rsp_afull;
  logic      rsp_empty;
  dmem_req_t req;
  dmem_req_t req_head;
  dmem_rsp_t rsp;
  dmem_rsp_t rsp_head;

  lsu_issue #(.XLEN(XLEN)) u_issue (
    .clk, .rstn, .ex_stall, .id_bubble, .id_instr, .id_exception, .opA, .opB,
    .req_afull, .lsu_stall, .lsu_bubble, .lsu_exception, .lsu_misaligned,
    .req_push, .req
  );

  // Request path
  lsu_fifo #(.DEPTH(FIFO_DEPTH), .T(dmem_req_t)) u_req_fifo (
    .clk, .rstn, .push(req_push), .din(req), .pop(req_pop),
    .dout(req_head), .empty(req_empty), .full(), .afull(req_afull)
  );

  dmem_ctrl #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) u_dmem (
    .clk, .rstn, .req_empty, .req_head, .rsp_afull, .req_pop, .rsp_push, .rsp
  );

  // Response path, popped only while an entry is present
  lsu_fifo #(.DEPTH(FIFO_DEPTH), .T(dmem_rsp_t)) u_rsp_fifo (
    .clk, .rstn, .push(rsp_push), .din(rsp), .pop(rsp_pop && rsp_valid),
    .dout(rsp_head), .empty(rsp_empty), .full(), .afull(rsp_afull)
  );

  assign rsp_valid = !rsp_empty;
  assign rsp_q     = rsp_head.q[XLEN-1:0];

endmodule

// File: tb/lsu_chk.sv
// FIFO and request checks, bound into lsu_top
// fail_count holds the number of assertion failures for the run summary

`timescale 1ns/1ps

module lsu_chk (
  input logic clk,
  input logic rstn,
  input logic req_push,
  input logic req_full,
  input logic req_pop,
  input logic req_empty,
  input logic rsp_push,
  input logic rsp_full,
  input logic lsu_misaligned
);

  int fail_count = 0;

  a_req_push_full: assert property (@(posedge clk) disable iff (!rstn) !(req_push && req_full))
    else begin
      fail_count++;
      $error("Push into a full request FIFO");
    end

  a_rsp_push_full: assert property (@(posedge clk) disable iff (!rstn) !(rsp_push && rsp_full))
    else begin
      fail_count++;
      $error("Push into a full response FIFO");
    end

  a_req_pop_empty: assert property (@(posedge clk) disable iff (!rstn) !(req_pop && req_empty))
    else begin
      fail_count++;
      $error("Pop from an empty request FIFO");
    end

  // Misaligned accesses never reach the request FIFO
  a_push_mis: assert property (@(posedge clk) disable iff (!rstn) !(req_push && lsu_misaligned))
    else begin
      fail_count++;
      $error("Request pushed with lsu_misaligned high");
    end

endmodule

bind lsu_top lsu_chk u_chk (
  .clk, .rstn, .req_push, .req_full(u_req_fifo.full), .req_pop, .req_empty,
  .rsp_push, .rsp_full(u_rsp_fifo.full), .lsu_misaligned
);

// File: tb/lsu_tb.sv
// Testbench for the load/store slice, built for XLEN 64 only
// The memory model is 256 bytes, which is 32 words of 8 bytes, upper address bits alias
// Load results are checked in issue order against an expected-value queue

`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int N_RAND  = 300;  // Mixed random instructions
  localparam int N_EXT   = 56;   // 8 stores, 48 signed/unsigned loads
  localparam int N_MIS   = 12;
  localparam int N_SWEEP = 32;   // Final LD of every word
  localparam int LIMIT   = 20 * (N_RAND + N_EXT + N_MIS + N_SWEEP) + 200;

  logic             clk = 1'b0;
  logic             rstn;
  logic             ex_stall;
  logic             id_bubble;
  logic [31:0]      id_instr;
  logic [EXC_W-1:0] id_exception;
  logic [63:0]      opA;
  logic [63:0]      opB;
  logic             lsu_stall;
  logic             lsu_bubble;
  logic [EXC_W-1:0] lsu_exception;
  logic             lsu_misaligned;
  logic             rsp_pop;
  logic             rsp_valid;
  logic [63:0]      rsp_q;

  integer      seed = 21;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          hold = 0;        // Cycles left with rsp_pop forced low
  bit          draining = 1'b0;
  bit          stall_seen = 1'b0;
  logic [7:0]  model [256];     // Byte mirror of the DUT memory
  logic [63:0] exp_q [$];       // Expected load results, oldest first

  lsu_top #(.XLEN(64), .FIFO_DEPTH(4), .MEM_WORDS(32)) u_dut (
    .clk, .rstn, .ex_stall, .id_bubble, .id_instr, .id_exception, .opA, .opB,
    .lsu_stall, .lsu_bubble, .lsu_exception, .lsu_misaligned,
    .rsp_pop, .rsp_valid, .rsp_q
  );

  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int unsigned pick(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [31:0] ld_instr(input logic [2:0] f3);
    return {12'h0, 5'd1, f3, 5'd2, 7'b0000011};  // Address comes from opA + opB
  endfunction

  function automatic logic [31:0] st_instr(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  // Reference behaviour of one accepted instruction
  task automatic apply_model(input logic [31:0] instr, input logic [15:0] exc,
                             input logic [63:0] a, input logic [63:0] b,
                             output logic exp_mis, output logic exp_push);
    logic [4:0]  op;
    logic [2:0]  f3;
    logic [63:0] imm;
    logic [63:0] adr;
    logic [63:0] v;
    logic        is_ld;
    logic        is_st;
    logic        legal;
    int          nb;
    op    = instr[6:2];
    f3    = instr[14:12];
    is_ld = (op == 5'b00000);
    is_st = (op == 5'b01000);
    imm   = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    adr   = is_st ? a + imm : a + b;
    nb    = 1 << f3[1:0];
    legal = is_ld ? (f3 != 3'b111) : (is_st && !f3[2]);  // Full RV64 set
    exp_mis  = legal && (adr % nb != 0) && (exc == 0);
    exp_push = legal && (adr % nb == 0) && (exc == 0);
    if (exp_push && is_st) begin
      for (int i = 0; i < nb; i++)
        model[adr[7:0] + i] = b[8*i +: 8];
    end else if (exp_push) begin
      v = '0;
      for (int i = 0; i < nb; i++)
        v[8*i +: 8] = model[adr[7:0] + i];
      if (!f3[2] && nb < 8 && v[8*nb-1])
        v = v | (~64'h0 << (8*nb));  // Sign fill
      exp_q.push_back(v);
    end
  endtask

  // Present one instruction, hold it through lsu_stall, then check the issue outputs
  task automatic issue(input logic [31:0] instr, input logic [15:0] exc,
                       input logic [63:0] a, input logic [63:0] b);
    logic stalled;
    logic exp_mis;
    logic exp_push;
    id_instr     = instr;
    id_exception = exc;
    opA          = a;
    opB          = b;
    id_bubble    = 1'b0;
    do begin
      stalled = lsu_stall;  // Stable between edges
      if (stalled)
        stall_seen = 1'b1;
      @(posedge clk);
      #1;
    end while (stalled);
    apply_model(instr, exc, a, b, exp_mis, exp_push);
    check_val(lsu_misaligned, exp_mis, "lsu_misaligned");
    check_val(lsu_bubble, exp_push ? 0 : 1, "lsu_bubble");
    check_val(lsu_exception, exc, "lsu_exception");
    id_bubble = 1'b1;
    if (pick(4) == 0) begin  // Occasional idle cycle
      @(posedge clk);
      #1;
    end
  endtask

  // One random load, store, or other opcode
  task automatic rand_op();
    int          kind;
    int          nb;
    logic [2:0]  f3;
    logic [7:0]  addr;
    logic [11:0] imm;
    logic [15:0] exc;
    logic [63:0] base;
    logic [63:0] r;
    kind = pick(16);
    addr = 8'(pick(256));
    base = rand64() & ~64'hFF;
    imm  = 12'(pick(4096));
    r    = rand64();
    exc  = (kind == 0 || kind == 14) ? (16'(pick(65536)) | 16'h1) : 16'h0;
    if (kind < 7) begin
      f3 = 3'(pick(4));
      nb = 1 << f3[1:0];
      if (kind != 1)
        addr = addr & ~8'(nb - 1);
      issue(st_instr(f3, imm), exc, base + addr - {{52{imm[11]}}, imm}, r);
    end else if (kind < 15) begin
      f3 = 3'(pick(7));
      nb = 1 << f3[1:0];
      if (kind != 8)
        addr = addr & ~8'(nb - 1);
      issue(ld_instr(f3), exc, base, 64'(addr));
    end else begin
      issue({r[31:7], 7'b0010011}, exc, base, r);  // OP-IMM, not a memory op
    end
  endtask

  //////////////////////////////
  // Response side
  //////////////////////////////
  initial begin
    logic [63:0] exp_v;
    rsp_pop = 1'b0;
    forever begin
      @(posedge clk);
      #2;  // After the driver at +1
      if (!rstn) begin
        rsp_pop = 1'b0;
      end else if (hold > 0 && !draining) begin
        hold--;
        rsp_pop = 1'b0;
      end else if (!draining && pick(64) == 0) begin
        hold    = 20 + pick(30);  // Back-pressure stretch
        rsp_pop = 1'b0;
      end else if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Load response at %0t ns with no load outstanding", $time);
        end else begin
          exp_v = exp_q.pop_front();
          check_val(rsp_q, exp_v, "rsp_q");
        end
        rsp_pop = 1'b1;
      end else begin
        rsp_pop = 1'b0;
      end
    end
  end

  // Run limit
  initial begin
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not complete within %0d cycles", LIMIT);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_chk.fail_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    logic [2:0]  f3;
    logic [7:0]  addr;
    logic [7:0]  off;
    int          total;
    rstn         = 1'b0;
    ex_stall     = 1'b0;
    id_bubble    = 1'b1;
    id_instr     = 32'h0;
    id_exception = '0;
    opA          = '0;
    opB          = '0;
    for (int i = 0; i < 256; i++)
      model[i] = 8'h00;  // Memory clears at reset
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    check_val(lsu_bubble, 1, "lsu_bubble after reset");
    check_val(lsu_stall, 0, "lsu_stall after reset");
    check_val(rsp_valid, 0, "rsp_valid after reset");

    for (int i = 0; i < N_RAND; i++)
      rand_op();

    // Sign vs zero extension on bytes with the top bit set
    for (int w = 0; w < 8; w++)
      issue(st_instr(F3_D, 12'h0), '0, 64'(64 + 8*w), rand64() | 64'h8080_8080_8080_8080);
    for (int w = 0; w < 8; w++) begin
      addr = 8'(64 + 8*w);
      for (int k = 0; k < 3; k++) begin
        f3  = 3'(k);
        off = (k == 0) ? 8'(pick(8)) : (k == 1) ? 8'(2 * pick(4)) : 8'(4 * pick(2));
        issue(ld_instr(f3), '0, rand64() & ~64'hFF, 64'(addr + off));
        issue(ld_instr(f3 | 3'b100), '0, rand64() & ~64'hFF, 64'(addr + off));
      end
    end

    // Odd addresses for halfword, word and doubleword
    for (int i = 0; i < N_MIS; i++) begin
      f3   = 3'(1 + i % 3);
      addr = 8'(8*i + 1 + 2*(i % 3));
      if (i % 2)
        issue(st_instr(f3, 12'h0), '0, 64'(addr), rand64());
      else
        issue(ld_instr(f3), '0, 64'h0, 64'(addr));
    end

    // Whole memory against the model
    for (int i = 0; i < N_SWEEP; i++)
      issue(ld_instr(F3_D), '0, rand64() & ~64'hFF, 64'(8*i));

    draining = 1'b1;
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (10) @(posedge clk);  // Room for any extra response to show
    #1;
    check_val(rsp_valid, 0, "rsp_valid after drain");
    if (!stall_seen) begin
      errors++;
      $display("lsu_stall never rose while responses were held back");
    end
    total = errors + u_dut.u_chk.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_chk.fail_count);
    if (total == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: flist.f
src/lsu_pkg.sv
src/lsu_issue.sv
src/lsu_fifo.sv
src/dmem_ctrl.sv
src/lsu_top.sv
tb/lsu_chk.sv
tb/lsu_tb.sv
